//--- src/rv_exec_pkg.sv
/*
 * rv_exec_pkg
 * Widths, opcodes, operation codes and the micro-op and retire
 * structs shared by the integer execute path.
 */
package rv_exec_pkg;

    // ----------------------------------------
    // widths and sizes
    // ----------------------------------------
    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int NUM_REGS    = 2 ** REG_ADDR_W;
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int DIV_CYCLES  = 32;
    localparam int DIV_CNT_W   = $clog2(DIV_CYCLES + 1);

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // ----------------------------------------
    // instruction fields
    // ----------------------------------------
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;
    localparam logic [6:0] F7_MULDIV  = 7'b0000001;

    // ----------------------------------------
    // operation codes
    // ----------------------------------------
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
        ALU_OR, ALU_AND, ALU_LUI, ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU, ALU_NOP
    } alu_op_e;

    typedef enum logic {
        SRC2_REG,
        SRC2_IMM
    } src2_sel_e;

    // same order as funct3[1:0] of the divide group
    typedef enum logic [1:0] {
        DOP_DIV, DOP_DIVU, DOP_REM, DOP_REMU
    } div_op_e;

    typedef struct packed {
        alu_op_e   op;
        src2_sel_e src2_sel;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;
    } uop_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } retire_t;

endpackage

//--- src/radix2_divider.sv
/*
 * radix2_divider
 * Restoring shift-subtract divider on operand magnitudes, one
 * quotient bit per cycle, with RISC-V sign and corner handling.
 */
`timescale 1ns/1ps

module radix2_divider
    import rv_exec_pkg::*;
(
    input  logic    clk,
    input  logic    reset_i,
    input  logic    start_i,
    input  div_op_e op_i,
    input  word_t   dividend_i,
    input  word_t   divisor_i,
    output logic    done_o,
    output word_t   result_o
);

    logic                 busy;
    logic [DIV_CNT_W-1:0] cnt;
    word_t                rem_q;
    word_t                quo_q;
    word_t                dvs_q;
    logic                 neg_quo;
    logic                 neg_rem;
    logic                 want_rem;
    logic                 dvs_zero;
    logic                 sgn;
    word_t                mag_a;
    word_t                mag_b;
    logic [XLEN:0]        shifted;
    logic [XLEN:0]        trial;
    word_t                rem_nxt;
    word_t                quo_nxt;

    assign sgn   = (op_i == DOP_DIV) || (op_i == DOP_REM);
    assign mag_a = (sgn && dividend_i[XLEN-1]) ? -dividend_i : dividend_i;
    assign mag_b = (sgn && divisor_i[XLEN-1]) ? -divisor_i : divisor_i;

    // one restoring step
    always_comb begin
        shifted = {rem_q, quo_q[XLEN-1]};
        trial   = shifted - {1'b0, dvs_q};
        rem_nxt = trial[XLEN] ? shifted[XLEN-1:0] : trial[XLEN-1:0];
        quo_nxt = {quo_q[XLEN-2:0], ~trial[XLEN]};
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy   <= 1'b0;
            cnt    <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                busy <= 1'b1;
                cnt  <= DIV_CNT_W'(DIV_CYCLES);
            end else if (busy) begin
                cnt <= cnt - 1'b1;
                if (cnt == DIV_CNT_W'(1)) begin
                    busy   <= 1'b0;
                    done_o <= 1'b1;
                end
            end
        end
    end

    // min / -1 needs no fix, the magnitude quotient negates back to the dividend
    always_ff @(posedge clk) begin
        if (start_i) begin
            rem_q    <= '0;
            quo_q    <= mag_a;
            dvs_q    <= mag_b;
            neg_quo  <= sgn && (dividend_i[XLEN-1] ^ divisor_i[XLEN-1]);
            neg_rem  <= sgn && dividend_i[XLEN-1];
            want_rem <= (op_i == DOP_REM) || (op_i == DOP_REMU);
            dvs_zero <= (divisor_i == '0);
        end else if (busy) begin
            rem_q <= rem_nxt;
            quo_q <= quo_nxt;
            if (cnt == DIV_CNT_W'(1)) begin
                if (want_rem) result_o <= neg_rem ? -rem_nxt : rem_nxt;
                else if (dvs_zero) result_o <= '1;
                else result_o <= neg_quo ? -quo_nxt : quo_nxt;
            end
        end
    end

endmodule

//--- src/int_reg_file.sv
/*
 * int_reg_file
 * 32 x XLEN integer registers, x0 reads as zero.
 * Two operand read ports and one debug read port.
 */
`timescale 1ns/1ps

module int_reg_file
    import rv_exec_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    input  reg_addr_t dbg_addr_i,
    output word_t     rs1_data_o,
    output word_t     rs2_data_o,
    output word_t     dbg_data_o,
    input  logic      wr_en_i,
    input  reg_addr_t wr_addr_i,
    input  word_t     wr_data_i
);

    word_t regs [1:NUM_REGS-1];

    function automatic word_t rd_port(input reg_addr_t addr);
        return (addr == '0) ? '0 : regs[addr];
    endfunction

    assign rs1_data_o = rd_port(rs1_addr_i);
    assign rs2_data_o = rd_port(rs2_addr_i);
    assign dbg_data_o = rd_port(dbg_addr_i);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && wr_addr_i != '0) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

endmodule

//--- src/inst_decoder.sv
/*
 * inst_decoder
 * Turns RV32I/M instruction words into micro-ops, registered
 * together with the push strobe. Unsupported words become NOPs.
 */
`timescale 1ns/1ps

module inst_decoder
    import rv_exec_pkg::*;
(
    input  logic  clk,
    input  logic  reset_i,
    input  logic  inst_valid_i,
    input  word_t inst_i,
    output logic  push_o,
    output uop_t  uop_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    uop_t       dec_uop;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    // shared by OP and OP-IMM, alt selects sub / sra
    function automatic alu_op_e base_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        dec_uop          = '0;
        dec_uop.op       = ALU_NOP;
        dec_uop.src2_sel = SRC2_REG;
        dec_uop.rs1      = inst_i[19:15];
        dec_uop.rs2      = inst_i[24:20];
        dec_uop.rd       = inst_i[11:7];
        dec_uop.imm      = {{(XLEN-12){inst_i[31]}}, inst_i[31:20]};

        case (opcode)
            OPC_OP: begin
                if (funct7 == F7_BASE) begin
                    dec_uop.op = base_op(funct3, 1'b0);
                end else if (funct7 == F7_ALT && (funct3 == 3'b000 || funct3 == 3'b101)) begin
                    dec_uop.op = base_op(funct3, 1'b1);
                end else if (funct7 == F7_MULDIV && funct3[2]) begin
                    // div divu rem remu, multiply stays a nop
                    dec_uop.op = alu_op_e'(ALU_DIV + funct3[1:0]);
                end
            end
            OPC_OP_IMM: begin
                dec_uop.src2_sel = SRC2_IMM;
                if (funct3 == 3'b001) begin
                    if (funct7 == F7_BASE) dec_uop.op = ALU_SLL;
                end else if (funct3 == 3'b101) begin
                    if (funct7 == F7_BASE || funct7 == F7_ALT) begin
                        dec_uop.op = base_op(funct3, funct7 == F7_ALT);
                    end
                end else begin
                    dec_uop.op = base_op(funct3, 1'b0);
                end
            end
            OPC_LUI: begin
                dec_uop.op       = ALU_LUI;
                dec_uop.src2_sel = SRC2_IMM;
                dec_uop.rs1      = '0;
                dec_uop.imm      = {inst_i[31:12], 12'b0};
            end
            default: ;
        endcase

        if (dec_uop.op == ALU_NOP) begin
            dec_uop.rd = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            push_o <= 1'b0;
        end else begin
            push_o <= inst_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid_i) begin
            uop_o <= dec_uop;
        end
    end

endmodule

//--- src/uop_queue.sv
/*
 * uop_queue
 * Circular FIFO of micro-ops. Each pop returns one credit to
 * the instruction source one cycle later.
 */
`timescale 1ns/1ps

module uop_queue
    import rv_exec_pkg::*;
(
    input  logic clk,
    input  logic reset_i,
    input  logic push_i,
    input  uop_t uop_i,
    input  logic pop_i,
    output uop_t head_o,
    output logic not_empty_o,
    output logic credit_o
);

    uop_t                   mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_CNT_W-1:0] count;

    function automatic logic [QUEUE_PTR_W-1:0] ptr_inc(input logic [QUEUE_PTR_W-1:0] p);
        return (p == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign head_o      = mem[rd_ptr];
    assign not_empty_o = (count != '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            credit_o <= pop_i;
            if (push_i) wr_ptr <= ptr_inc(wr_ptr);
            if (pop_i) rd_ptr <= ptr_inc(rd_ptr);
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // storage, no reset
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= uop_i;
        end
    end

endmodule

//--- src/exec_unit.sv
/*
 * exec_unit
 * Pops one micro-op at a time, runs it on the ALU or the divider,
 * writes the register file and produces the retire record.
 */
`timescale 1ns/1ps

module exec_unit
    import rv_exec_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  uop_t      head_i,
    input  logic      not_empty_i,
    output logic      pop_o,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    output logic      wr_en_o,
    output reg_addr_t wr_addr_o,
    output word_t     wr_data_o,
    output retire_t   retire_o
);

    typedef enum logic [1:0] {ST_IDLE, ST_ALU, ST_DIV_WAIT} state_e;

    state_e    state;
    alu_op_e   op_q;
    reg_addr_t rd_q;
    word_t     opa_q;
    word_t     opb_q;
    logic      div_start;
    div_op_e   div_op;
    logic      div_done;
    word_t     div_result;
    word_t     alu_result;
    word_t     result;
    logic      finish;
    logic      head_is_div;

    assign rs1_addr_o  = head_i.rs1;
    assign rs2_addr_o  = head_i.rs2;
    assign pop_o       = (state == ST_IDLE) && not_empty_i;
    assign head_is_div = head_i.op inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};

    // ----------------------------------------
    // sequencer
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state     <= ST_IDLE;
            div_start <= 1'b0;
        end else begin
            div_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (pop_o) begin
                        state     <= head_is_div ? ST_DIV_WAIT : ST_ALU;
                        div_start <= head_is_div;
                    end
                end
                ST_ALU:      state <= ST_IDLE;
                ST_DIV_WAIT: if (div_done) state <= ST_IDLE;
                default:     state <= ST_IDLE;
            endcase
        end
    end

    // operands latched at pop
    always_ff @(posedge clk) begin
        if (pop_o) begin
            op_q  <= head_i.op;
            rd_q  <= head_i.rd;
            opa_q <= rs1_data_i;
            opb_q <= (head_i.src2_sel == SRC2_IMM) ? head_i.imm : rs2_data_i;
        end
    end

    // ----------------------------------------
    // alu
    // ----------------------------------------
    always_comb begin
        case (op_q)
            ALU_ADD:  alu_result = opa_q + opb_q;
            ALU_SUB:  alu_result = opa_q - opb_q;
            ALU_SLL:  alu_result = opa_q << opb_q[4:0];
            ALU_SLT:  alu_result = word_t'($signed(opa_q) < $signed(opb_q));
            ALU_SLTU: alu_result = word_t'(opa_q < opb_q);
            ALU_XOR:  alu_result = opa_q ^ opb_q;
            ALU_SRL:  alu_result = opa_q >> opb_q[4:0];
            ALU_SRA:  alu_result = word_t'($signed(opa_q) >>> opb_q[4:0]);
            ALU_OR:   alu_result = opa_q | opb_q;
            ALU_AND:  alu_result = opa_q & opb_q;
            ALU_LUI:  alu_result = opb_q;
            default:  alu_result = '0;
        endcase
    end

    always_comb begin
        case (op_q)
            ALU_DIVU: div_op = DOP_DIVU;
            ALU_REM:  div_op = DOP_REM;
            ALU_REMU: div_op = DOP_REMU;
            default:  div_op = DOP_DIV;
        endcase
    end

    radix2_divider u_radix2_divider_0 (
        .clk        (clk),
        .reset_i    (reset_i),
        .start_i    (div_start),
        .op_i       (div_op),
        .dividend_i (opa_q),
        .divisor_i  (opb_q),
        .done_o     (div_done),
        .result_o   (div_result)
    );

    // ----------------------------------------
    // write back and retire
    // ----------------------------------------
    assign finish    = (state == ST_ALU) || (state == ST_DIV_WAIT && div_done);
    assign result    = (state == ST_DIV_WAIT) ? div_result : alu_result;
    assign wr_en_o   = finish && (rd_q != '0);
    assign wr_addr_o = rd_q;
    assign wr_data_o = result;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            retire_o.valid <= 1'b0;
        end else begin
            retire_o.valid <= finish;
            if (finish) begin
                retire_o.rd   <= rd_q;
                // x0 target reports zero
                retire_o.data <= (rd_q == '0) ? '0 : result;
            end
        end
    end

endmodule

//--- src/rv_exec_core.sv
/*
 * rv_exec_core
 * Integer execute path: decoder, micro-op queue, execute unit
 * and register file, fed through a credit-based input.
 */
`timescale 1ns/1ps

module rv_exec_core
    import rv_exec_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      inst_valid_i,
    input  word_t     inst_i,
    output logic      inst_credit_o,
    output retire_t   retire_o,
    input  reg_addr_t dbg_addr_i,
    output word_t     dbg_data_o
);

    logic      push;
    uop_t      dec_uop;
    logic      pop;
    uop_t      head_uop;
    logic      not_empty;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;

    inst_decoder u_inst_decoder_0 (
        .clk          (clk),
        .reset_i      (reset_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .push_o       (push),
        .uop_o        (dec_uop)
    );

    uop_queue u_uop_queue_0 (
        .clk         (clk),
        .reset_i     (reset_i),
        .push_i      (push),
        .uop_i       (dec_uop),
        .pop_i       (pop),
        .head_o      (head_uop),
        .not_empty_o (not_empty),
        .credit_o    (inst_credit_o)
    );

    exec_unit u_exec_unit_0 (
        .clk         (clk),
        .reset_i     (reset_i),
        .head_i      (head_uop),
        .not_empty_i (not_empty),
        .pop_o       (pop),
        .rs1_addr_o  (rs1_addr),
        .rs2_addr_o  (rs2_addr),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .wr_en_o     (wr_en),
        .wr_addr_o   (wr_addr),
        .wr_data_o   (wr_data),
        .retire_o    (retire_o)
    );

    int_reg_file u_int_reg_file_0 (
        .clk        (clk),
        .reset_i    (reset_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .dbg_addr_i (dbg_addr_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .dbg_data_o (dbg_data_o),
        .wr_en_i    (wr_en),
        .wr_addr_i  (wr_addr),
        .wr_data_i  (wr_data)
    );

endmodule

//--- bench/tb_program.svh
/*
 * tb_program
 * Instruction table for the execute path testbench: instruction
 * words, expected retire records and idle gaps. The final register
 * values are the last value the table writes to each register.
 */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int GAP_RANDOM = -1;
localparam int MAX_GAP    = 3;

typedef struct packed {
    word_t   inst;
    retire_t exp;
    int      gap;
} step_t;

step_t program_q [$];
word_t final_regs [NUM_REGS];

// ----------------------------------------
// instruction encoders
// ----------------------------------------
function automatic word_t encode_r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                        input reg_addr_t rs1, input logic [2:0] f3,
                                        input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic word_t encode_i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                        input logic [2:0] f3, input reg_addr_t rd);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
endfunction

function automatic word_t encode_lui(input logic [19:0] imm, input reg_addr_t rd);
    return {imm, rd, OPC_LUI};
endfunction

task automatic add_step(input word_t inst, input reg_addr_t rd, input word_t data,
                        input int gap);
    step_t st;
    st.inst      = inst;
    st.exp.valid = 1'b1;
    st.exp.rd    = rd;
    st.exp.data  = data;
    st.gap       = gap;
    program_q.push_back(st);
    if (rd != '0) begin
        final_regs[rd] = data;
    end
endtask

task automatic load_program();
    foreach (final_regs[i]) begin
        final_regs[i] = '0;
    end
    // x1 gets 100, x2 gets -7 and x3 the most negative value
    add_step(encode_i_type(12'd100, 5'd0, 3'b000, 5'd1), 5'd1, 32'h0000_0064, 0);
    add_step(encode_i_type(12'hFF9, 5'd0, 3'b000, 5'd2), 5'd2, 32'hFFFF_FFF9, 1);
    add_step(encode_lui(20'h80000, 5'd3), 5'd3, 32'h8000_0000, 0);
    // register and immediate alu forms
    add_step(encode_r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd4), 5'd4, 32'h0000_005D, 2);
    add_step(encode_r_type(7'h20, 5'd1, 5'd2, 3'b000, 5'd5), 5'd5, 32'hFFFF_FF95, 0);
    add_step(encode_r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd6), 5'd6, 32'h0000_0001, GAP_RANDOM);
    add_step(encode_r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd7), 5'd7, 32'h0000_0000, GAP_RANDOM);
    add_step(encode_i_type(12'h401, 5'd2, 3'b101, 5'd8), 5'd8, 32'hFFFF_FFFC, 0);
    add_step(encode_i_type(12'h001, 5'd2, 3'b101, 5'd9), 5'd9, 32'h7FFF_FFFC, 0);
    add_step(encode_i_type(12'h004, 5'd1, 3'b001, 5'd10), 5'd10, 32'h0000_0640, 1);
    add_step(encode_i_type(12'h0FF, 5'd1, 3'b100, 5'd11), 5'd11, 32'h0000_009B, GAP_RANDOM);
    add_step(encode_r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd12), 5'd12, 32'hFFFF_FFFD, 0);
    add_step(encode_r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd13), 5'd13, 32'h0000_0060, 0);
    add_step(encode_r_type(7'h20, 5'd1, 5'd3, 3'b101, 5'd14), 5'd14, 32'hF800_0000, 3);
    add_step(encode_r_type(7'h00, 5'd1, 5'd3, 3'b101, 5'd15), 5'd15, 32'h0800_0000, 0);
    add_step(encode_i_type(12'd5, 5'd2, 3'b010, 5'd16), 5'd16, 32'h0000_0001, 0);
    // divide chain sent back to back
    add_step(encode_r_type(7'h01, 5'd2, 5'd1, 3'b100, 5'd17), 5'd17, 32'hFFFF_FFF2, 0);
    add_step(encode_r_type(7'h01, 5'd2, 5'd1, 3'b110, 5'd18), 5'd18, 32'h0000_0002, 0);
    add_step(encode_r_type(7'h01, 5'd1, 5'd2, 3'b101, 5'd19), 5'd19, 32'h028F_5C28, 0);
    add_step(encode_r_type(7'h01, 5'd1, 5'd2, 3'b111, 5'd20), 5'd20, 32'h0000_0059, 0);
    add_step(encode_r_type(7'h01, 5'd0, 5'd2, 3'b100, 5'd21), 5'd21, 32'hFFFF_FFFF, 0);
    add_step(encode_r_type(7'h01, 5'd0, 5'd2, 3'b110, 5'd22), 5'd22, 32'hFFFF_FFF9, 0);
    add_step(encode_r_type(7'h01, 5'd0, 5'd1, 3'b101, 5'd23), 5'd23, 32'hFFFF_FFFF, 0);
    add_step(encode_r_type(7'h01, 5'd0, 5'd1, 3'b111, 5'd24), 5'd24, 32'h0000_0064, 0);
    add_step(encode_i_type(12'hFFF, 5'd0, 3'b000, 5'd25), 5'd25, 32'hFFFF_FFFF, 0);
    add_step(encode_r_type(7'h01, 5'd25, 5'd3, 3'b100, 5'd26), 5'd26, 32'h8000_0000, 0);
    add_step(encode_r_type(7'h01, 5'd25, 5'd3, 3'b110, 5'd27), 5'd27, 32'h0000_0000, 0);
    add_step(encode_r_type(7'h01, 5'd25, 5'd3, 3'b101, 5'd28), 5'd28, 32'h0000_0000, 0);
    add_step(encode_r_type(7'h01, 5'd25, 5'd3, 3'b111, 5'd29), 5'd29, 32'h8000_0000, 0);
    // x0 target, multiply and a branch all retire as rd 0
    add_step(encode_i_type(12'd5, 5'd1, 3'b000, 5'd0), 5'd0, 32'h0000_0000, GAP_RANDOM);
    add_step(encode_r_type(7'h01, 5'd1, 5'd1, 3'b000, 5'd30), 5'd0, 32'h0000_0000, GAP_RANDOM);
    // beq x1, x1, 8 with rd field 8
    add_step(32'h0010_8463, 5'd0, 32'h0000_0000, 0);
    add_step(encode_r_type(7'h00, 5'd5, 5'd4, 3'b000, 5'd31), 5'd31, 32'hFFFF_FFF2, GAP_RANDOM);
endtask

`endif

//--- bench/tb_rv_exec_core.sv
/*
 * tb_rv_exec_core
 * Testbench for the integer execute path: credit-tracking driver,
 * retire monitor, debug register sweeps and a watchdog.
 */
`timescale 1ns/1ps

module tb_rv_exec_core
    import rv_exec_pkg::*;
();

    logic      clk;
    logic      reset_i;
    logic      inst_valid_i;
    word_t     inst_i;
    logic      inst_credit_o;
    retire_t   retire_o;
    reg_addr_t dbg_addr_i;
    word_t     dbg_data_o;

    retire_t   expected_q [$];
    retire_t   expected_rec;
    int        errors;
    int        checks;
    int        sent;
    int        retired;
    int        credit_pulses;
    int        credits;
    bit        loaded;
    bit        saw_no_credit;

    `include "tb_program.svh"

    rv_exec_core rv_exec_core_inst (
        .clk           (clk),
        .reset_i       (reset_i),
        .inst_valid_i  (inst_valid_i),
        .inst_i        (inst_i),
        .inst_credit_o (inst_credit_o),
        .retire_o      (retire_o),
        .dbg_addr_i    (dbg_addr_i),
        .dbg_data_o    (dbg_data_o)
    );

    always #2 clk = ~clk;

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------
    task automatic check_retire(input retire_t got, input retire_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %0b/x%0d/%08h expected %0b/x%0d/%08h",
                     $time, what, got.valid, got.rd, got.data, exp.valid, exp.rd, exp.data);
        end
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %08h expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic finish_run(input bit timed_out);
        $display("checks %0d, errors %0d, sent %0d, retired %0d, credits back %0d",
                 checks, errors, sent, retired, credit_pulses);
        if (errors == 0 && !timed_out) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    // ----------------------------------------
    // driver
    // ----------------------------------------
    // next falling edge, picking up a returned credit
    task automatic step_clock();
        @(negedge clk);
        if (inst_credit_o === 1'b1) begin
            credits++;
            if (credits > QUEUE_DEPTH) begin
                errors++;
                $display("more credits than queue entries at time %0t", $time);
            end
        end
    endtask

    task automatic send_program();
        step_t st;
        int    gap;
        foreach (program_q[i]) begin
            st  = program_q[i];
            gap = (st.gap == GAP_RANDOM) ? int'($urandom % (MAX_GAP + 1)) : st.gap;
            step_clock();
            inst_valid_i = 1'b0;
            repeat (gap) step_clock();
            while (credits == 0) begin
                saw_no_credit = 1'b1;
                step_clock();
            end
            inst_valid_i = 1'b1;
            inst_i       = st.inst;
            credits--;
            sent++;
        end
        step_clock();
        inst_valid_i = 1'b0;
    endtask

    task automatic sweep_registers(input bit after_program);
        word_t expect_val;
        for (int a = 0; a < NUM_REGS; a++) begin
            @(negedge clk);
            dbg_addr_i = reg_addr_t'(a);
            #1;
            expect_val = after_program ? final_regs[a] : '0;
            check_word(dbg_data_o, expect_val, $sformatf("debug read x%0d", a));
            check_flag(retire_o.valid, 1'b0, "retire valid while idle");
            check_flag(inst_credit_o, 1'b0, "credit while idle");
        end
    endtask

    // ----------------------------------------
    // monitor
    // ----------------------------------------
    always @(negedge clk) begin
        if (!reset_i) begin
            if (inst_credit_o === 1'b1) begin
                credit_pulses++;
                if (credit_pulses > sent) begin
                    errors++;
                    $display("credit pulse at time %0t with nothing outstanding", $time);
                end
            end
            if (retire_o.valid === 1'b1) begin
                if (expected_q.size() == 0) begin
                    errors++;
                    $display("retire at time %0t with no record expected", $time);
                end else begin
                    expected_rec = expected_q.pop_front();
                    check_retire(retire_o, expected_rec, $sformatf("retire %0d", retired));
                end
                retired++;
            end
        end
    end

    initial begin
        void'($urandom(14));
        clk          = 1'b0;
        reset_i      = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        dbg_addr_i   = '0;
        load_program();
        foreach (program_q[i]) begin
            expected_q.push_back(program_q[i].exp);
        end
        loaded = 1'b1;

        repeat (4) begin
            @(negedge clk);
            check_flag(retire_o.valid, 1'b0, "retire valid in reset");
            check_flag(inst_credit_o, 1'b0, "credit in reset");
        end
        reset_i = 1'b0;
        sweep_registers(1'b0);

        credits = QUEUE_DEPTH;
        send_program();
        while (retired < program_q.size() || credits < QUEUE_DEPTH) begin
            step_clock();
        end
        // stray retires or credits show up here
        repeat (8) step_clock();

        if (credit_pulses != sent) begin
            errors++;
            $display("%0d credits came back for %0d instructions", credit_pulses, sent);
        end
        if (expected_q.size() != 0) begin
            errors++;
            $display("%0d retire records never arrived", expected_q.size());
        end
        if (!saw_no_credit) begin
            errors++;
            $display("the divide chain never used up the credits");
        end
        sweep_registers(1'b1);
        finish_run(1'b0);
    end

    // ----------------------------------------
    // watchdog
    // ----------------------------------------
    initial begin
        int limit_ns;
        wait (loaded);
        limit_ns = program_q.size() * (DIV_CYCLES + MAX_GAP + 8) * 4 * 2;
        #(limit_ns);
        $display("timeout after %0d ns, the run did not complete", limit_ns);
        finish_run(1'b1);
    end

endmodule

//--- build.f
+incdir+bench
src/rv_exec_pkg.sv
src/radix2_divider.sv
src/int_reg_file.sv
src/inst_decoder.sv
src/uop_queue.sv
src/exec_unit.sv
src/rv_exec_core.sv
bench/tb_rv_exec_core.sv

//--- run.sh
#!/bin/sh
# build and run the execute path testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_rv_exec_core &&
    ./obj_dir/Vtb_rv_exec_core | tee /dev/stderr | grep -x "ALL CHECKS PASSED" > /dev/null &&
    echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }
